/* files.f */
design/fp80_pkg.sv
design/reduce_pkg.sv
design/fp80_subtract.sv
design/angle_reducer.sv
design/large_angle_engine.sv
design/trig_reduce_unit.sv
sim/reduce_checker.sv
sim/tb_trig_reduce.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the range-reduction testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_trig_reduce_sim

verilator --binary -Wno-fatal -f files.f --top-module tb_trig_reduce -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi

/* sim/tb_trig_reduce.sv */
// Testbench top: clock, reset, stimulus table, drive loop, watchdog and final verdict
`timescale 1ns/1ns
`default_nettype none

module tb_trig_reduce;
    import fp80_pkg::*;

    localparam real HALF_PI     = 1.5707963267948966;
    localparam int  MAX_ENTRIES = 128;

    logic       clk;
    logic       reset;
    logic       enable;
    fp80_word   angle_in;
    fp80_word   angle_out;
    logic [1:0] quadrant;
    logic       done;
    logic       error;

    // Expected result of the case currently driven
    logic        expect_error;
    logic [1:0]  expect_quadrant;
    logic [63:0] expect_offset_bits;
    logic        expect_abs;
    int          case_index;
    int          error_count;
    int          check_count;

    // Stimulus table, one row per case
    fp80_word    stim_word [MAX_ENTRIES];
    logic        stim_error [MAX_ENTRIES];
    logic [1:0]  stim_quadrant [MAX_ENTRIES];
    real         stim_offset [MAX_ENTRIES];
    logic        stim_abs [MAX_ENTRIES];
    int          entry_count;

    trig_reduce_unit #(
        .MAX_ITERATIONS (200)
    ) dut (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .angle_in  (angle_in),
        .angle_out (angle_out),
        .quadrant  (quadrant),
        .done      (done),
        .error     (error)
    );

    reduce_checker u_checker (
        .clk                (clk),
        .reset              (reset),
        .enable             (enable),
        .done               (done),
        .error              (error),
        .quadrant           (quadrant),
        .angle_out          (angle_out),
        .expect_error       (expect_error),
        .expect_quadrant    (expect_quadrant),
        .expect_offset_bits (expect_offset_bits),
        .expect_abs         (expect_abs),
        .case_index         (case_index),
        .error_count        (error_count),
        .check_count        (check_count)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // ======================================================================
    // Table helpers
    // ======================================================================

    // Double to extended, exact since the 52-bit fraction fits under the integer bit
    function automatic fp80_word to_fp80(input real value);
        logic [63:0] bits;
        fp80_word    word;
        bits = $realtobits(value);
        if (bits[62:0] == 63'd0) begin
            word = 80'd0;
        end else begin
            word.fields.sign     = bits[63];
            word.fields.exponent = 15'(bits[62:52]) + 15'd15360;
            word.fields.mantissa = {1'b1, bits[51:0], 11'd0};
        end
        return word;
    endfunction

    // Offset kept well inside a quadrant, 0.1 to 0.9 of pi/2
    function automatic real random_offset();
        return HALF_PI * (0.1 + 0.8 * real'($urandom % 10000) / 10000.0);
    endfunction

    task automatic add_raw(input fp80_word word, input logic err, input logic [1:0] quad,
                           input real offset, input logic abs_tol);
        stim_word[entry_count]     = word;
        stim_error[entry_count]    = err;
        stim_quadrant[entry_count] = quad;
        stim_offset[entry_count]   = offset;
        stim_abs[entry_count]      = abs_tol;
        entry_count++;
    endtask

    // k*pi/2 + r, engine cases from k = 200 get the absolute tolerance
    task automatic add_angle(input int k, input real r);
        add_raw(to_fp80(real'(k) * HALF_PI + r), 1'b0, 2'(k % 4), r, k >= 200);
    endtask

    // ======================================================================
    // Stimulus and drive loop
    // ======================================================================

    initial begin
        void'($urandom(76));
        clk                = 1'b0;
        reset              = 1'b1;
        enable             = 1'b0;
        angle_in           = 80'd0;
        expect_error       = 1'b0;
        expect_quadrant    = 2'd0;
        expect_offset_bits = 64'd0;
        expect_abs         = 1'b1;
        case_index         = -1;
        entry_count        = 0;

        // Zero, infinity, NaN, exponent past the engine limit
        add_raw(80'd0, 1'b0, 2'd0, 0.0, 1'b1);
        add_raw(80'h7FFF_8000000000000000, 1'b1, 2'd0, 0.0, 1'b1);
        add_raw(80'h7FFF_C000000000000000, 1'b1, 2'd0, 0.0, 1'b1);
        add_raw(80'h4040_8000000000000000, 1'b1, 2'd0, 0.0, 1'b1);
        // First quadrant inputs come back unchanged
        for (int i = 0; i < 3; i++) begin
            add_angle(0, random_offset());
        end
        // Iterative loop path
        for (int k = 1; k <= 60; k++) begin
            add_angle(k, random_offset());
        end
        // Engine path, fixed and random multiples
        add_angle(200, random_offset());
        add_angle(201, random_offset());
        add_angle(202, random_offset());
        add_angle(203, random_offset());
        add_angle(1000, random_offset());
        add_angle(12345, random_offset());
        add_angle(65537, random_offset());
        add_angle(999999, random_offset());
        for (int i = 0; i < 4; i++) begin
            add_angle(200 + int'($urandom % 999800), random_offset());
        end

        repeat (5) @(posedge clk);
        #5;
        reset = 1'b0;

        for (int i = 0; i < entry_count; i++) begin
            case_index         = i;
            expect_error       = stim_error[i];
            expect_quadrant    = stim_quadrant[i];
            expect_offset_bits = $realtobits(stim_offset[i]);
            expect_abs         = stim_abs[i];
            angle_in           = stim_word[i];
            enable             = 1'b1;
            do begin
                @(posedge clk);
                #5;
            end while (!done);
            // Release the result and wait for the unit to go idle
            enable = 1'b0;
            do begin
                @(posedge clk);
                #5;
            end while (done);
        end

        repeat (2) @(posedge clk);
        $display("Cases: %0d  checks: %0d  errors: %0d", entry_count, check_count, error_count);
        if (check_count != entry_count) begin
            $display("Not every case produced a done pulse");
        end
        if ((error_count == 0) && (check_count == entry_count)) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog, 600 cycles per case plus reset
    initial begin
        #1;
        repeat ((entry_count * 600) + 20) @(posedge clk);
        $display("Timeout: the DUT did not finish all %0d cases in time", entry_count);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/reduce_checker.sv */
// Result checker: samples DUT outputs on done, converts to real, compares and counts errors
`timescale 1ns/1ns
`default_nettype none

module reduce_checker (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     enable,
    input  wire                     done,
    input  wire                     error,
    input  wire [1:0]               quadrant,
    input  wire fp80_pkg::fp80_word angle_out,
    input  wire                     expect_error,
    input  wire [1:0]               expect_quadrant,
    input  wire [63:0]              expect_offset_bits,
    input  wire                     expect_abs,
    input  wire signed [31:0]       case_index,
    output int                      error_count,
    output int                      check_count
);
    import fp80_pkg::*;

    logic done_prev;
    // Done was high with enable low on the last edge
    logic release_prev;

    // Extended to double, low mantissa bits dropped
    function automatic real to_real(input fp80_word word);
        if (word.fields.exponent == 15'd0) begin
            return 0.0;
        end
        return $bitstoreal({1'b0, 11'(word.fields.exponent - 15'd15360),
                            word.fields.mantissa[62:11]});
    endfunction

    // ======================================================================
    // Compare on the rising edge of done
    // ======================================================================

    always @(posedge clk or posedge reset) begin
        real  got;
        real  want;
        real  delta;
        logic value_ok;
        int   new_errors;
        if (reset) begin
            error_count  <= 0;
            check_count  <= 0;
            done_prev    <= 1'b0;
            release_prev <= 1'b0;
        end else begin
            new_errors = 0;
            if (done && !done_prev) begin
                check_count <= check_count + 1;
                if (expect_error) begin
                    // Only the flag matters, angle_out is stale
                    if (!error) begin
                        $display("FAIL %0t: case %0d error flag is 0, expected 1",
                                 $time, case_index);
                        new_errors++;
                    end
                end else begin
                    got   = to_real(angle_out);
                    want  = $bitstoreal(expect_offset_bits);
                    delta = (got > want) ? (got - want) : (want - got);
                    // Absolute for the engine, relative for the loop
                    value_ok = expect_abs ? (delta <= 1.0e-6) : (delta <= 1.0e-9 * want);
                    if (error) begin
                        $display("FAIL %0t: case %0d error flag is 1, expected 0",
                                 $time, case_index);
                        new_errors++;
                    end
                    if (quadrant != expect_quadrant) begin
                        $display("FAIL %0t: case %0d quadrant %0d, expected %0d",
                                 $time, case_index, quadrant, expect_quadrant);
                        new_errors++;
                    end
                    if (!value_ok) begin
                        $display("FAIL %0t: case %0d angle_out %.12g, expected %.12g",
                                 $time, case_index, got, want);
                        new_errors++;
                    end
                end
            end
            // Flags clear one cycle after the release
            if (release_prev && (done || error)) begin
                $display("FAIL %0t: case %0d done or error still set after enable dropped",
                         $time, case_index);
                new_errors++;
            end
            release_prev <= done && !enable;
            done_prev    <= done;
            error_count  <= error_count + new_errors;
        end
    end

endmodule

`default_nettype wire

/* design/trig_reduce_unit.sv */
// Top of the range-reduction unit, joins the reducer FSM and the large-angle engine
`timescale 1ns/1ns
`default_nettype none

module trig_reduce_unit #(
    parameter int MAX_ITERATIONS = 200
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     enable,
    input  wire fp80_pkg::fp80_word angle_in,
    output fp80_pkg::fp80_word      angle_out,
    output logic [1:0]              quadrant,
    output logic                    done,
    output logic                    error
);
    import fp80_pkg::*;

    // Reducer to engine link
    logic       engine_start;
    fp80_word   engine_angle;
    logic       engine_done;
    fp80_word   engine_result;
    logic [1:0] engine_quadrant;
    logic       engine_error;

    angle_reducer #(
        .MAX_ITERATIONS (MAX_ITERATIONS)
    ) u_reducer (
        .clk             (clk),
        .reset           (reset),
        .enable          (enable),
        .angle_in        (angle_in),
        .engine_done     (engine_done),
        .engine_result   (engine_result),
        .engine_quadrant (engine_quadrant),
        .engine_error    (engine_error),
        .angle_out       (angle_out),
        .quadrant        (quadrant),
        .done            (done),
        .error           (error),
        .engine_start    (engine_start),
        .engine_angle    (engine_angle)
    );

    // Handles exponents from 256 up
    large_angle_engine u_engine (
        .clk      (clk),
        .reset    (reset),
        .start    (engine_start),
        .angle    (engine_angle),
        .result   (engine_result),
        .quadrant (engine_quadrant),
        .done     (engine_done),
        .error    (engine_error)
    );

endmodule

`default_nettype wire

/* design/large_angle_engine.sv */
// Large-angle engine: scaled 2pi subtraction per exponent step, then quadrant selection
`timescale 1ns/1ns
`default_nettype none

module large_angle_engine (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     start,
    input  wire fp80_pkg::fp80_word angle,
    output fp80_pkg::fp80_word      result,
    output logic [1:0]              quadrant,
    output logic                    done,
    output logic                    error
);
    import fp80_pkg::*;
    import reduce_pkg::*;

    localparam logic [1:0] E_IDLE     = 2'd0;
    localparam logic [1:0] E_STEP     = 2'd1;
    localparam logic [1:0] E_QUAD_SEL = 2'd2;
    localparam logic [1:0] E_QUAD_SUB = 2'd3;

    logic [1:0] state;
    // At most 0x403E - 0x4001 = 61
    logic [5:0] step;
    fp80_word   working;
    fp80_word   scaled;
    fp80_word   step_diff;
    fp80_word   quad_b;
    fp80_word   quad_diff;
    logic       step_ge;
    logic       quad_ge;

    // 2pi times 2^step
    always_comb begin
        scaled                 = FP80_TWO_PI;
        scaled.fields.exponent = TWO_PI_EXP + {9'd0, step};
    end

    fp80_subtract u_sub_step (
        .a    (working),
        .b    (scaled),
        .diff (step_diff)
    );

    // pi first, then pi/2, one bit of quadrant per cycle
    assign quad_b = (state == E_QUAD_SEL) ? FP80_PI : FP80_PI_OVER_2;

    fp80_subtract u_sub_quad (
        .a    (working),
        .b    (quad_b),
        .diff (quad_diff)
    );

    assign step_ge = working.mag.magnitude >= scaled.mag.magnitude;
    assign quad_ge = working.mag.magnitude >= quad_b.mag.magnitude;

    // ======================================================================
    // Sequencer
    // ======================================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= E_IDLE;
            step  <= 6'd0;
            done  <= 1'b0;
            error <= 1'b0;
        end else begin
            done  <= 1'b0;
            error <= 1'b0;
            case (state)
                E_IDLE: begin
                    // Start while busy never reaches here
                    if (start) begin
                        if (angle.fields.exponent > ENGINE_EXP_LIMIT) begin
                            done  <= 1'b1;
                            error <= 1'b1;
                        end else if (angle.fields.exponent < TWO_PI_EXP) begin
                            // Already below 2pi
                            state <= E_QUAD_SEL;
                        end else begin
                            step  <= 6'(angle.fields.exponent - TWO_PI_EXP);
                            state <= E_STEP;
                        end
                    end
                end
                E_STEP: begin
                    if (step == 6'd0) begin
                        state <= E_QUAD_SEL;
                    end else begin
                        step <= step - 6'd1;
                    end
                end
                E_QUAD_SEL: begin
                    state <= E_QUAD_SUB;
                end
                default: begin
                    done  <= 1'b1;
                    state <= E_IDLE;
                end
            endcase
        end
    end

    // Working value and results
    always_ff @(posedge clk) begin
        case (state)
            E_IDLE: begin
                if (start) begin
                    working <= {1'b0, angle.mag.magnitude};
                end
            end
            E_STEP: begin
                // Value stays below twice the current scaled 2pi
                if (step_ge) begin
                    working <= step_diff;
                end
            end
            E_QUAD_SEL: begin
                quadrant[1] <= quad_ge;
                if (quad_ge) begin
                    working <= quad_diff;
                end
            end
            default: begin
                quadrant[0] <= quad_ge;
                result      <= quad_ge ? quad_diff : working;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/angle_reducer.sv */
// Reducer FSM: special-value dispatch, iterative 2pi loop, quadrant select, engine hand-off
`timescale 1ns/1ns
`default_nettype none

module angle_reducer #(
    parameter int MAX_ITERATIONS = 200
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     enable,
    input  wire fp80_pkg::fp80_word angle_in,
    input  wire                     engine_done,
    input  wire fp80_pkg::fp80_word engine_result,
    input  wire [1:0]               engine_quadrant,
    input  wire                     engine_error,
    output fp80_pkg::fp80_word      angle_out,
    output logic [1:0]              quadrant,
    output logic                    done,
    output logic                    error,
    output logic                    engine_start,
    output fp80_pkg::fp80_word      engine_angle
);
    import fp80_pkg::*;
    import reduce_pkg::*;

    localparam int ITER_W = $clog2(MAX_ITERATIONS + 1);

    reducer_state state;
    fp80_word     working;
    logic [ITER_W-1:0] iteration_count;

    fp80_word sub_b;
    fp80_word sub_diff;
    fp80_word sub3_diff;

    logic is_zero;
    logic is_special;
    logic is_large;
    logic ge_2pi;
    logic ge_pi;
    logic ge_pi_2;
    logic ge_3pi_2;

    // ======================================================================
    // Input classification through the fields view
    // ======================================================================

    assign is_zero    = (angle_in.fields.exponent == 15'd0) &&
                        (angle_in.fields.mantissa == 64'd0);
    // Infinity or any NaN
    assign is_special = angle_in.fields.exponent == EXP_ALL_ONES;
    assign is_large   = angle_in.fields.exponent >= LARGE_EXP_THRESHOLD;

    // Ordered compares of the working value
    assign ge_2pi  = working.mag.magnitude >= FP80_TWO_PI.mag.magnitude;
    assign ge_pi   = working.mag.magnitude >= FP80_PI.mag.magnitude;
    assign ge_pi_2 = working.mag.magnitude >= FP80_PI_OVER_2.mag.magnitude;

    // Loop step takes 2pi, quadrant step takes pi or pi/2
    assign sub_b = (state == ST_SUB_2PI) ? FP80_TWO_PI :
                   (ge_pi ? FP80_PI : FP80_PI_OVER_2);

    fp80_subtract u_sub_main (
        .a    (working),
        .b    (sub_b),
        .diff (sub_diff)
    );

    // Second stage removes the extra pi/2 for quadrant 3
    fp80_subtract u_sub_chain (
        .a    (sub_diff),
        .b    (FP80_PI_OVER_2),
        .diff (sub3_diff)
    );

    // Working minus pi still at or above pi/2
    assign ge_3pi_2 = ge_pi && (sub_diff.mag.magnitude >= FP80_PI_OVER_2.mag.magnitude);

    // ======================================================================
    // Control FSM
    // ======================================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state           <= ST_IDLE;
            done            <= 1'b0;
            error           <= 1'b0;
            quadrant        <= 2'd0;
            iteration_count <= '0;
            engine_start    <= 1'b0;
        end else begin
            engine_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    iteration_count <= '0;
                    if (enable) begin
                        state <= ST_DISPATCH;
                    end
                end
                ST_DISPATCH: begin
                    if (is_zero) begin
                        quadrant <= 2'd0;
                        done     <= 1'b1;
                        state    <= ST_DONE;
                    end else if (is_special) begin
                        error <= 1'b1;
                        done  <= 1'b1;
                        state <= ST_DONE;
                    end else if (is_large) begin
                        engine_start <= 1'b1;
                        state        <= ST_ENGINE_WAIT;
                    end else begin
                        state <= ST_CHECK_RANGE;
                    end
                end
                ST_CHECK_RANGE: begin
                    // Cap bounds the loop on a stuck value
                    if (ge_2pi && (iteration_count < ITER_W'(MAX_ITERATIONS))) begin
                        iteration_count <= iteration_count + 1'b1;
                        state           <= ST_SUB_2PI;
                    end else begin
                        state <= ST_FIND_QUADRANT;
                    end
                end
                ST_SUB_2PI: begin
                    state <= ST_CHECK_RANGE;
                end
                ST_FIND_QUADRANT: begin
                    if (ge_pi) begin
                        quadrant <= ge_3pi_2 ? 2'd3 : 2'd2;
                    end else begin
                        quadrant <= ge_pi_2 ? 2'd1 : 2'd0;
                    end
                    if (ge_pi_2) begin
                        state <= ST_SUB_QUAD;
                    end else begin
                        // Already in first quadrant
                        done  <= 1'b1;
                        state <= ST_DONE;
                    end
                end
                ST_SUB_QUAD: begin
                    state <= ST_FINALIZE;
                end
                ST_FINALIZE: begin
                    done  <= 1'b1;
                    state <= ST_DONE;
                end
                ST_ENGINE_WAIT: begin
                    if (engine_done) begin
                        quadrant <= engine_quadrant;
                        error    <= engine_error;
                        done     <= 1'b1;
                        state    <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    // Result held until the caller lets go
                    if (!enable) begin
                        done  <= 1'b0;
                        error <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Data path registers follow the FSM state
    always_ff @(posedge clk) begin
        case (state)
            ST_DISPATCH: begin
                // Sign dropped, angle treated as a magnitude
                working      <= {1'b0, angle_in.mag.magnitude};
                engine_angle <= angle_in;
                if (is_zero) begin
                    angle_out <= FP80_ZERO;
                end
            end
            ST_SUB_2PI: begin
                working <= sub_diff;
            end
            ST_FIND_QUADRANT: begin
                if (!ge_pi_2) begin
                    angle_out <= working;
                end
            end
            ST_SUB_QUAD: begin
                working <= (quadrant == 2'd3) ? sub3_diff : sub_diff;
            end
            ST_FINALIZE: begin
                angle_out <= working;
            end
            ST_ENGINE_WAIT: begin
                if (engine_done) begin
                    angle_out <= engine_result;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/fp80_subtract.sv */
// Combinational magnitude subtractor for extended values with leading-one normalization
`timescale 1ns/1ns
`default_nettype none

module fp80_subtract (
    input  wire fp80_pkg::fp80_word a,
    input  wire fp80_pkg::fp80_word b,
    output fp80_pkg::fp80_word      diff
);
    import fp80_pkg::*;

    logic [14:0] exp_diff;
    logic [63:0] b_aligned;
    logic [63:0] mant_diff;
    logic [5:0]  lead_pos;
    logic [5:0]  norm_shift;
    logic [63:0] norm_mant;
    logic [14:0] norm_exp;
    logic        b_larger;

    // ======================================================================
    // Alignment and raw difference
    // ======================================================================

    // Both operands normalized and nonnegative, so the magnitude view orders them
    assign b_larger = b.mag.magnitude > a.mag.magnitude;

    // Valid only when a is not smaller, the b_larger case is forced to zero below
    assign exp_diff = a.fields.exponent - b.fields.exponent;

    always_comb begin
        // Shift past the mantissa width leaves nothing
        if (exp_diff >= 15'd64) begin
            b_aligned = 64'd0;
        end else begin
            b_aligned = b.fields.mantissa >> exp_diff;
        end
    end

    assign mant_diff = a.fields.mantissa - b_aligned;

    // ======================================================================
    // Normalization
    // ======================================================================

    // Ascending scan, the last hit is the highest set bit
    always_comb begin
        lead_pos = 6'd0;
        for (int i = 0; i < 64; i++) begin
            if (mant_diff[i]) begin
                lead_pos = 6'(i);
            end
        end
    end

    // Move the leading one back to the integer bit
    assign norm_shift = 6'd63 - lead_pos;
    assign norm_mant  = mant_diff << norm_shift;
    assign norm_exp   = a.fields.exponent - {9'd0, norm_shift};

    // Negative or exact-zero results collapse to zero
    always_comb begin
        if (b_larger || (mant_diff == 64'd0)) begin
            diff = FP80_ZERO;
        end else begin
            diff.fields.sign     = 1'b0;
            diff.fields.exponent = norm_exp;
            diff.fields.mantissa = norm_mant;
        end
    end

endmodule

`default_nettype wire

/* design/reduce_pkg.sv */
// Reducer state encoding, large-angle dispatch threshold and engine exponent bounds
`default_nettype none

package reduce_pkg;

    // Control states of the reducer
    typedef enum logic [3:0] {
        ST_IDLE          = 4'd0,
        ST_DISPATCH      = 4'd1,
        ST_CHECK_RANGE   = 4'd2,
        ST_SUB_2PI       = 4'd3,
        ST_FIND_QUADRANT = 4'd4,
        ST_SUB_QUAD      = 4'd5,
        ST_FINALIZE      = 4'd6,
        ST_ENGINE_WAIT   = 4'd7,
        ST_DONE          = 4'd8
    } reducer_state;

    // Exponent of 256, angles at or above go to the engine
    localparam logic [14:0] LARGE_EXP_THRESHOLD = 15'h4007;

    // Largest exponent the engine accepts, 2^64 and above is an error
    localparam logic [14:0] ENGINE_EXP_LIMIT = 15'h403E;

    // Exponent of 2pi, also the last engine step
    localparam logic [14:0] TWO_PI_EXP = 15'h4001;

endpackage

`default_nettype wire

/* design/fp80_pkg.sv */
// 80-bit extended value layout with its two decoded views, angle constants, special exponent
`default_nettype none

package fp80_pkg;

    // ======================================================================
    // Extended precision word
    // ======================================================================

    // Fields view for classification and arithmetic
    // Magnitude view for ordered compares of nonnegative values
    typedef union packed {
        struct packed {
            logic        sign;
            logic [14:0] exponent;
            // Explicit integer bit at [63]
            logic [63:0] mantissa;
        } fields;
        struct packed {
            logic        sign_bit;
            logic [78:0] magnitude;
        } mag;
    } fp80_word;

    // ======================================================================
    // Angle constants
    // ======================================================================

    // Same mantissa, exponent steps of one
    localparam fp80_word FP80_TWO_PI    = 80'h4001_C90FDAA22168C235;
    localparam fp80_word FP80_PI        = 80'h4000_C90FDAA22168C235;
    localparam fp80_word FP80_PI_OVER_2 = 80'h3FFF_C90FDAA22168C235;
    localparam fp80_word FP80_ZERO      = 80'h0000_0000000000000000;

    // Infinity and NaN share this exponent
    localparam logic [14:0] EXP_ALL_ONES = 15'h7FFF;

endpackage

`default_nettype wire
